// File: Makefile
# verilator build and run for the instruction cache testbench
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# the testbench reads its golden file relative to the project root
run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: icache.f
logic/icache_geom_pkg.sv
logic/icache_addr_pkg.sv
logic/icache_tagmem.sv
logic/icache_datamem.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

// File: logic/icache_addr_pkg.sv
package icache_addr_pkg;

	import icache_geom_pkg::*;

	// ==============================
	// fetch address format
	// ==============================

	// byte bits below the word select, always zero for fetches
	localparam int byte_sel_bits = offset_bits - word_sel_bits;

	typedef logic [index_bits-1:0] line_index_t;
	typedef logic [word_sel_bits-1:0] word_sel_t;

	// one address word, seen either flat or split into fields
	// flat view is used for burst address math
	// field view gives tag, line index and word select
	typedef union packed {
		logic [addr_width-1:0] flat;
		struct packed {
			logic [tag_bits-1:0] tag;
			line_index_t index;
			// offset inside the line
			struct packed {
				word_sel_t word;
				logic [byte_sel_bits-1:0] byte_sel;
			} offset;
		} fields;
	} fetch_addr_u;

endpackage

// File: logic/icache_ctrl.sv
module icache_ctrl
	import icache_geom_pkg::*;
	import icache_addr_pkg::*;
(
	input  logic                  rclk,
	input  logic                  reset,
	// requester side
	input  logic                  fetch_req,
	input  fetch_addr_u           fetch_addr,
	output logic                  fetch_ready,
	// lookup into tag and data memories
	output logic                  lookup,
	output fetch_addr_u           lookup_addr,
	input  logic                  hit,
	// external memory burst
	output logic                  mem_rd,
	output logic [addr_width-1:0] mem_addr,
	input  logic                  mem_ack,
	input  logic                  mem_err,
	// fill writes
	output logic                  data_wr,
	output word_sel_t             fill_word,
	output logic                  tag_wr,
	output logic                  fill_err
);

	// ==============================
	// state
	// ==============================

	// one hot flags, idle means none of the three is set
	logic st_compare;
	logic st_fill;
	logic st_twrite;
	logic st_idle;
	// rest cycle after a response
	logic rest;

	// fill bookkeeping
	word_sel_t fill_cnt;
	logic err_acc;
	logic miss;
	logic last_ack;

	assign st_idle = ~(st_compare | st_fill | st_twrite);

	// requester holds the address for the whole request
	assign lookup_addr = fetch_addr;
	// strobe the arrays as soon as a request is seen
	// after a fill this is the recheck of the same address
	assign lookup = st_idle & fetch_req & ~rest;

	// compare cycle sees the registered lookup result
	assign fetch_ready = st_compare & hit;
	assign miss = st_compare & ~hit;

	assign mem_rd = st_fill;
	assign data_wr = st_fill & mem_ack;
	assign fill_word = fill_cnt;
	assign last_ack = data_wr && (fill_cnt == word_sel_t'(line_words - 1));

	assign tag_wr = st_twrite;
	assign fill_err = err_acc;

	always_ff @(posedge rclk) begin
		if (reset) begin
			st_compare <= 1'b0;
			st_fill <= 1'b0;
			st_twrite <= 1'b0;
			rest <= 1'b0;
		end else begin
			st_compare <= lookup;
			// stay in the burst until the eighth word
			st_fill <= miss | (st_fill & ~last_ack);
			st_twrite <= last_ack;
			rest <= fetch_ready;
		end
	end

	// ==============================
	// burst address and fill count
	// ==============================

	always_ff @(posedge rclk) begin
		if (miss) begin
			// burst starts at the line aligned address
			mem_addr <= {fetch_addr.flat[addr_width-1:offset_bits], {offset_bits{1'b0}}};
			fill_cnt <= '0;
			err_acc <= 1'b0;
		end else if (data_wr) begin
			mem_addr <= mem_addr + addr_width'(word_bytes);
			fill_cnt <= fill_cnt + 1'b1;
			// any bad word marks the whole line
			err_acc <= err_acc | mem_err;
		end
	end

	// memory only answers an open burst
	a_ack_in_burst: assert property (@(posedge rclk) disable iff (reset)
		mem_ack |-> mem_rd);

endmodule

// File: logic/icache_datamem.sv
module icache_datamem
	import icache_geom_pkg::*;
	import icache_addr_pkg::*;
(
	input  logic                      rclk,
	// word write port, used by the line fill
	input  logic                      wr,
	input  line_index_t               windex,
	input  word_sel_t                 wword,
	input  logic [word_bytes*8-1:0]   wdata,
	// word read port
	input  logic                      rce,
	input  fetch_addr_u               ra,
	output logic [word_bytes*8-1:0]   rdata
);

	// ==============================
	// line data array
	// ==============================

	// 256 lines x 8 words, addressed as {index, word}
	logic [word_bytes*8-1:0] data_mem [num_lines*line_words];

	// one word per fill acknowledge
	always_ff @(posedge rclk) begin
		if (wr) begin
			data_mem[{windex, wword}] <= wdata;
		end
	end

	// registered read
	// word is valid the cycle after rce and holds until the next rce
	always_ff @(posedge rclk) begin
		if (rce) begin
			rdata <= data_mem[{ra.fields.index, ra.fields.offset.word}];
		end
	end

	// write strobe from the controller must be clean at every edge
	a_wr_known: assert property (@(posedge rclk)
		!$isunknown(wr));

endmodule

// File: logic/icache_geom_pkg.sv
package icache_geom_pkg;

	// ==============================
	// cache geometry
	// ==============================

	// byte address from the fetch unit
	localparam int addr_width = 32;

	// one fetch word is 32 bits
	localparam int word_bytes = 4;

	// 8 words make one 32 byte line
	localparam int line_words = 8;

	// direct mapped, 256 lines -> 8 KB
	localparam int num_lines = 256;

	// address split: tag | index | word select | byte
	localparam int index_bits = 8;
	localparam int offset_bits = 5;
	localparam int word_sel_bits = 3;

	// tag is address bits 31..13
	localparam int tag_bits = 19;

endpackage

// File: logic/icache_tagmem.sv
module icache_tagmem
	import icache_geom_pkg::*;
	import icache_addr_pkg::*;
(
	input  logic        rclk,
	input  logic        reset,
	// lookup side
	input  logic        rce,
	input  fetch_addr_u ra,
	// line fill side
	input  logic        wr,
	input  fetch_addr_u wa,
	input  logic        err_in,
	// invalidation
	input  logic        invalidate,
	input  logic        invalidate_line,
	input  fetch_addr_u invalidate_addr,
	// lookup result, one cycle after rce
	output logic        hit,
	output logic        err_out
);

	// ==============================
	// storage
	// ==============================

	// one tag per line
	logic [tag_bits-1:0] tag_mem [num_lines];
	// per line status bits
	logic [num_lines-1:0] valid;
	logic [num_lines-1:0] err_bits;

	// registered lookup address
	fetch_addr_u ra_q;

	// tag only changes on a fill
	always_ff @(posedge rclk) begin
		if (wr) begin
			tag_mem[wa.fields.index] <= wa.fields.tag;
		end
	end

	// status bits
	// global invalidate wins over line invalidate, which wins over a fill
	// line invalidate leaves the error bit alone
	always_ff @(posedge rclk) begin
		if (reset || invalidate) begin
			valid <= '0;
			err_bits <= '0;
		end else if (invalidate_line) begin
			valid[invalidate_addr.fields.index] <= 1'b0;
		end else if (wr) begin
			valid[wa.fields.index] <= 1'b1;
			err_bits[wa.fields.index] <= err_in;
		end
	end

	// ==============================
	// lookup
	// ==============================

	always_ff @(posedge rclk) begin
		if (reset) begin
			ra_q <= '0;
		end else if (rce) begin
			ra_q <= ra;
		end
	end

	// stored tag matches and the line is live
	assign hit = valid[ra_q.fields.index] && (tag_mem[ra_q.fields.index] == ra_q.fields.tag);
	assign err_out = err_bits[ra_q.fields.index];

	// fill tag write and global invalidate are never issued together
	a_wr_not_inval: assert property (@(posedge rclk) disable iff (reset)
		!(wr && invalidate));

	// lookup result is always defined once out of reset
	a_hit_known: assert property (@(posedge rclk) disable iff (reset)
		!$isunknown(hit));

endmodule

// File: logic/icache_top.sv
module icache_top
	import icache_geom_pkg::*;
	import icache_addr_pkg::*;
(
	input  logic                    rclk,
	input  logic                    reset,
	// requester side
	input  logic                    fetch_req,
	input  logic [addr_width-1:0]   fetch_addr,
	output logic                    fetch_ready,
	output logic [word_bytes*8-1:0] fetch_data,
	output logic                    fetch_err,
	input  logic                    invalidate,
	input  logic                    invalidate_line,
	input  logic [addr_width-1:0]   invalidate_addr,
	// memory side
	output logic                    mem_rd,
	output logic [addr_width-1:0]   mem_addr,
	input  logic                    mem_ack,
	input  logic [word_bytes*8-1:0] mem_data,
	input  logic                    mem_err
);

	// controller to arrays
	logic lookup;
	fetch_addr_u lookup_addr;
	logic hit;
	logic data_wr;
	word_sel_t fill_word;
	logic tag_wr;
	logic fill_err;

	// ==============================
	// controller
	// ==============================

	icache_ctrl u_ctrl (
		.rclk        (rclk),
		.reset       (reset),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.lookup      (lookup),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.mem_rd      (mem_rd),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_err     (mem_err),
		.data_wr     (data_wr),
		.fill_word   (fill_word),
		.tag_wr      (tag_wr),
		.fill_err    (fill_err)
	);

	// ==============================
	// arrays
	// ==============================

	// invalidates come straight from the ports
	icache_tagmem u_tagmem (
		.rclk            (rclk),
		.reset           (reset),
		.rce             (lookup),
		.ra              (lookup_addr),
		.wr              (tag_wr),
		.wa              (lookup_addr),
		.err_in          (fill_err),
		.invalidate      (invalidate),
		.invalidate_line (invalidate_line),
		.invalidate_addr (invalidate_addr),
		.hit             (hit),
		.err_out         (fetch_err)
	);

	// fill writes land in the line of the pending request
	icache_datamem u_datamem (
		.rclk   (rclk),
		.wr     (data_wr),
		.windex (lookup_addr.fields.index),
		.wword  (fill_word),
		.wdata  (mem_data),
		.rce    (lookup),
		.ra     (lookup_addr),
		.rdata  (fetch_data)
	);

endmodule

// File: tests/icache_checker.sv
module icache_checker (
	input  logic        rclk,
	input  logic        reset,
	// DUT requester side
	input  logic        fetch_req,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_ready,
	input  logic [31:0] fetch_data,
	input  logic        fetch_err,
	// DUT memory side
	input  logic        mem_rd,
	input  logic [31:0] mem_addr,
	input  logic        mem_ack,
	// expected values of the fetch in flight
	input  logic [31:0] exp_data,
	input  logic        exp_err,
	input  logic        exp_fill,
	output int          error_count,
	output int          check_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int errors = 0;
	int checks = 0;

	// per request bookkeeping
	logic req_q = 1'b0;
	logic fill_seen = 1'b0;
	int wait_cycles = 0;
	int ack_cnt = 0;
	logic [31:0] burst_addr = '0;

	assign error_count = errors;
	assign check_count = checks;

	task automatic report(input string what, input logic [31:0] got, input logic [31:0] want);
		errors++;
		$display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h (fetch 0x%08h)",
			$time, what, got, want, fetch_addr);
	endtask

	// ==============================
	// response compare
	// ==============================

	task automatic check_response();
		checks++;
		if (fetch_data !== exp_data)
			report("fetch_data", fetch_data, exp_data);
		if (fetch_err !== exp_err)
			report("fetch_err", 32'(fetch_err), 32'(exp_err));
		if (fill_seen !== exp_fill)
			report("fill flag", 32'(fill_seen), 32'(exp_fill));
		// a fill reads the whole line, a hit answers one cycle after the request
		if (exp_fill) begin
			if (ack_cnt != 8)
				report("acknowledge count", 32'(ack_cnt), 32'd8);
		end else if (wait_cycles != 1) begin
			report("hit latency", 32'(wait_cycles), 32'd1);
		end
	endtask

	always @(posedge rclk) begin
		if (reset) begin
			req_q = 1'b0;
			fill_seen = 1'b0;
			wait_cycles = 0;
			ack_cnt = 0;
		end else begin
			// new request on the rising level
			if (fetch_req && !req_q) begin
				fill_seen = 1'b0;
				wait_cycles = 0;
				ack_cnt = 0;
				burst_addr = {fetch_addr[31:5], 5'b0};
			end
			if (fetch_req) begin
				if (mem_rd)
					fill_seen = 1'b1;
				// burst walks the line upwards one word per acknowledge
				if (mem_ack) begin
					if (mem_addr !== burst_addr)
						report("burst address", mem_addr, burst_addr);
					burst_addr = burst_addr + 32'd4;
					ack_cnt++;
				end
				if (fetch_ready)
					check_response();
				else
					wait_cycles++;
			end else if (mem_rd || fetch_ready) begin
				errors++;
				$display("[ERROR] %0t: DUT active with no fetch pending", $time);
			end
			req_q = fetch_req;
		end
	end

endmodule

// File: tests/icache_golden.txt
# op addr data err fill, all hex; op F fetch, L line invalidate, I global invalidate
# data err fill are the expected response of a fetch and are zero for invalidates
F 00001040 3C3CB5E5 0 1
F 0000105C 3C3CB5F9 0 0
F 00001044 3C3CB5E1 0 0
F 00003040 3C3C95E5 0 1
F 00001040 3C3CB5E5 0 1
F 00001060 3C3CB5C5 0 1
L 00001040 00000000 0 0
F 00001060 3C3CB5C5 0 0
F 00001048 3C3CB5ED 0 1
I 00000000 00000000 0 0
F 00001060 3C3CB5C5 0 1
F 0000104C 3C3CB5E9 0 1
F 00001FFC 3C3CBA59 0 1
F 00001FE0 3C3CBA45 0 0
F 7FFFE020 43C34585 0 1
F EFFFFFE0 D3C35A45 0 1
F F0000100 CC3CA4A5 1 1
F F0000114 CC3CA4B1 1 0
F F000011C CC3CA4B9 1 0
I 00000000 00000000 0 0
F 00000100 3C3CA4A5 0 1
F 00000104 3C3CA4A1 0 0

// File: tests/icache_tb.sv
module icache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 16;
	localparam int cycles_per_op = 60;

	logic rclk;
	logic reset;
	logic fetch_req;
	logic [31:0] fetch_addr;
	logic fetch_ready;
	logic [31:0] fetch_data;
	logic fetch_err;
	logic invalidate;
	logic invalidate_line;
	logic [31:0] invalidate_addr;
	logic mem_rd;
	logic [31:0] mem_addr;
	// memory model outputs
	logic mem_ack = 1'b0;
	logic [31:0] mem_data = '0;
	logic mem_err = 1'b0;
	int unsigned ack_wait = 0;

	// expected values handed to the checker
	logic [31:0] exp_data;
	logic exp_err;
	logic exp_fill;

	// golden operations, one entry per file line
	byte op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic err_q[$];
	logic fill_q[$];
	int num_ops = 0;
	int num_fetches = 0;
	bit loaded = 1'b0;
	int unsigned seed;
	int error_count;
	int check_count;

	icache_top DUT (.*);

	icache_checker u_checker (.*);

	initial begin
		rclk = 1'b0;
		forever #4 rclk = ~rclk;
	end

	// ==============================
	// memory model
	// ==============================

	// word at A is A ^ 3C3CA5A5, 0 to 3 idle cycles before each ack
	always @(posedge rclk) begin
		mem_ack <= 1'b0;
		if (mem_rd && !mem_ack) begin
			if (ack_wait == 0) begin
				mem_ack <= 1'b1;
				mem_data <= mem_addr ^ 32'h3C3C_A5A5;
				mem_err <= (mem_addr >= 32'hF000_0000);
				ack_wait <= $urandom_range(3, 0);
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end
	end

	task automatic load_golden(output bit ok);
		int fd;
		int n;
		string line;
		byte op;
		logic [31:0] a, d, e, f;
		ok = 1'b0;
		fd = $fopen("tests/icache_golden.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h %h", op, a, d, e, f);
			if (n == 5) begin
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
				err_q.push_back(e[0]);
				fill_q.push_back(f[0]);
				if (op == "F")
					num_fetches++;
			end
		end
		$fclose(fd);
		num_ops = op_q.size();
		ok = (num_ops > 0);
	endtask

	task automatic run_fetch(input logic [31:0] addr, input logic [31:0] data,
		input logic err, input logic fill);
		@(posedge rclk);
		exp_data <= data;
		exp_err <= err;
		exp_fill <= fill;
		fetch_addr <= addr;
		fetch_req <= 1'b1;
		// level stays up until the response pulse
		do begin
			@(posedge rclk);
		end while (!fetch_ready);
		fetch_req <= 1'b0;
	endtask

	task automatic pulse_invalidate(input logic all_lines, input logic [31:0] addr);
		@(posedge rclk);
		if (all_lines) begin
			invalidate <= 1'b1;
		end else begin
			invalidate_line <= 1'b1;
			invalidate_addr <= addr;
		end
		@(posedge rclk);
		invalidate <= 1'b0;
		invalidate_line <= 1'b0;
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		seed = $urandom(5);
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		invalidate = 1'b0;
		invalidate_line = 1'b0;
		invalidate_addr = '0;
		exp_data = '0;
		exp_err = 1'b0;
		exp_fill = 1'b0;
		load_golden(loaded);
		if (!loaded) begin
			$display("golden file tests/icache_golden.txt is missing or holds no operations");
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			repeat (reset_cycles) @(posedge rclk);
			reset <= 1'b0;
			foreach (op_q[i]) begin
				case (op_q[i])
					"F": run_fetch(addr_q[i], data_q[i], err_q[i], fill_q[i]);
					"L": pulse_invalidate(1'b0, addr_q[i]);
					default: pulse_invalidate(1'b1, addr_q[i]);
				endcase
			end
			repeat (4) @(posedge rclk);
			$display("run complete: %0d fetches, %0d responses checked, %0d errors",
				num_fetches, check_count, error_count);
			if (error_count == 0 && check_count == num_fetches) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

	// every operation gets a fixed budget of cycles
	initial begin
		wait (loaded);
		repeat (reset_cycles + num_ops * cycles_per_op) @(posedge rclk);
		$display("run timed out after %0d operations worth of cycles", num_ops);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
